//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run one simulation
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module raycaster_tb -f tb.f -o raycaster_sim

output=$(./obj_dir/raycaster_sim 2>&1) || true
echo "$output"
if echo "$output" | grep -qx "PASS: all tests"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- source/pixel_scanner.sv
// Frame control for the renderer
// Raster counters, per-pixel go pulse and linear pixel address
`timescale 1ns/100ps
`include "raycast_settings.svh"

module pixel_scanner (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         pixel_write_en,
    output logic                         pixel_go,
    output logic [`PIXEL_COORD_BITS-1:0] pixel_x,
    output logic [`PIXEL_COORD_BITS-1:0] pixel_y,
    output logic [31:0]                  pixel_addr,
    output logic                         busy,
    output logic                         done
);

    localparam logic [`PIXEL_COORD_BITS-1:0] LAST_X = (`PIXEL_COORD_BITS)'(`SCREEN_WIDTH - 1);
    localparam logic [`PIXEL_COORD_BITS-1:0] LAST_Y = (`PIXEL_COORD_BITS)'(`SCREEN_HEIGHT - 1);

    logic                         pixel_open;
    logic                         last_x;
    logic                         last_y;
    logic [`PIXEL_COORD_BITS-1:0] next_x;
    logic [`PIXEL_COORD_BITS-1:0] next_y;

    assign last_x = (pixel_x == LAST_X);
    assign last_y = (pixel_y == LAST_Y);
    assign next_x = last_x ? '0 : pixel_x + 1'b1;
    assign next_y = last_x ? pixel_y + 1'b1 : pixel_y;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            pixel_go   <= 1'b0;
            pixel_open <= 1'b0;
            pixel_x    <= '0;
            pixel_y    <= '0;
            pixel_addr <= '0;
        end else begin
            pixel_go <= 1'b0;
            done     <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy       <= 1'b1;
                    pixel_go   <= 1'b1;
                    pixel_x    <= '0;
                    pixel_y    <= '0;
                    pixel_addr <= '0;
                end
            end else if (pixel_go) begin
                pixel_open <= 1'b1;
            end else if (pixel_write_en && pixel_open) begin
                // Pixel finished, move on or close the frame
                pixel_open <= 1'b0;
                if (last_x && last_y) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else begin
                    pixel_x    <= next_x;
                    pixel_y    <= next_y;
                    pixel_addr <= 32'(next_y) * 32'(`SCREEN_WIDTH) + 32'(next_x);
                    pixel_go   <= 1'b1;
                end
            end
        end
    end

    // Only one pixel may be in flight through the chain
    assert property (@(posedge clk) disable iff (!rst_n) pixel_go |-> !pixel_open);

endmodule

//--- source/ray_marcher.sv
// Ray stepping through the voxel volume
// Voxel fetch, hit test and latch of the hit word and coordinates
`timescale 1ns/100ps
`include "raycast_settings.svh"

module ray_marcher import raycast_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              ray_valid,
    input  logic signed [`ACC_BITS-1:0]       ray_pos_x,
    input  logic signed [`ACC_BITS-1:0]       ray_pos_y,
    input  logic signed [`ACC_BITS-1:0]       ray_pos_z,
    input  logic signed [`ACC_BITS-1:0]       ray_dir_x,
    input  logic signed [`ACC_BITS-1:0]       ray_dir_y,
    input  logic signed [`ACC_BITS-1:0]       ray_dir_z,
    input  voxel_word_t                       voxel_data,
    output logic        [`VOXEL_ADDR_BITS-1:0]  voxel_addr,
    output logic                              voxel_read_en,
    output logic                              march_done,
    output logic                              hit,
    output logic        [`VOXEL_COORD_BITS-1:0] hit_x,
    output logic        [`VOXEL_COORD_BITS-1:0] hit_y,
    output logic        [`VOXEL_COORD_BITS-1:0] hit_z,
    output voxel_word_t                       hit_word,
    output logic        [7:0]                 steps
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ADDR  = 2'd1;
    localparam logic [1:0] S_FETCH = 2'd2;

    localparam int unsigned VB = `VOXEL_COORD_BITS;
    localparam logic [7:0] MAX_STEPS = 8'(`MAX_RAY_STEPS);
    localparam logic [7:0] ALPHA_MIN = 8'(`ALPHA_HIT_MIN);

    logic [1:0]                  state;
    logic signed [`ACC_BITS-1:0] pos_x, pos_y, pos_z;
    logic signed [`ACC_BITS-1:0] dir_x, dir_y, dir_z;
    logic                        voxel_hit;

    // Occupied and opaque enough to stop the ray
    assign voxel_hit = (voxel_data.raw != '0) && (voxel_data.fields.alpha > ALPHA_MIN);

    // ----------------------------------------
    // March control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            voxel_read_en <= 1'b0;
            march_done    <= 1'b0;
            hit           <= 1'b0;
            steps         <= '0;
        end else begin
            voxel_read_en <= 1'b0;
            march_done    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (ray_valid) begin
                        steps <= '0;
                        hit   <= 1'b0;
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    voxel_read_en <= 1'b1;
                    state         <= S_FETCH;
                end
                S_FETCH: begin
                    steps <= steps + 8'd1;
                    if (voxel_hit || steps == MAX_STEPS - 8'd1) begin
                        hit        <= voxel_hit;
                        march_done <= 1'b1;
                        state      <= S_IDLE;
                    end else begin
                        state <= S_ADDR;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Ray position and fetch address
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (state == S_IDLE && ray_valid) begin
            pos_x <= ray_pos_x;
            pos_y <= ray_pos_y;
            pos_z <= ray_pos_z;
            dir_x <= ray_dir_x;
            dir_y <= ray_dir_y;
            dir_z <= ray_dir_z;
        end else if (state == S_ADDR) begin
            // Integer part of each position, wrapped to the grid
            voxel_addr <= {pos_x[`FRAC_BITS +: VB], pos_y[`FRAC_BITS +: VB],
                           pos_z[`FRAC_BITS +: VB]};
            pos_x <= pos_x + dir_x;
            pos_y <= pos_y + dir_y;
            pos_z <= pos_z + dir_z;
        end
        if (state == S_FETCH && voxel_hit) begin
            hit_word <= voxel_data;
            hit_x    <= voxel_addr[2*VB +: VB];
            hit_y    <= voxel_addr[VB +: VB];
            hit_z    <= voxel_addr[0 +: VB];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) voxel_read_en |-> steps < MAX_STEPS);
    assert property (@(posedge clk) disable iff (!rst_n) march_done |=> !march_done);

endmodule

//--- source/ray_setup.sv
// Per-pixel ray origin and direction registers
`timescale 1ns/100ps
`include "raycast_settings.svh"

module ray_setup (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                pixel_go,
    input  logic        [`PIXEL_COORD_BITS-1:0] pixel_x,
    input  logic        [`PIXEL_COORD_BITS-1:0] pixel_y,
    input  logic signed [`CAM_BITS-1:0]         cam_x,
    input  logic signed [`CAM_BITS-1:0]         cam_y,
    input  logic signed [`CAM_BITS-1:0]         cam_z,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_x,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_y,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_z,
    input  logic signed [`CAM_BITS-1:0]         cam_plane_x,
    input  logic signed [`CAM_BITS-1:0]         cam_plane_y,
    output logic                                ray_valid,
    output logic signed [`ACC_BITS-1:0]         ray_pos_x,
    output logic signed [`ACC_BITS-1:0]         ray_pos_y,
    output logic signed [`ACC_BITS-1:0]         ray_pos_z,
    output logic signed [`ACC_BITS-1:0]         ray_dir_x,
    output logic signed [`ACC_BITS-1:0]         ray_dir_y,
    output logic signed [`ACC_BITS-1:0]         ray_dir_z
);

    localparam logic signed [`ACC_BITS-1:0] HALF_W = (`ACC_BITS)'(`SCREEN_WIDTH / 2);
    localparam logic signed [`ACC_BITS-1:0] HALF_H = (`ACC_BITS)'(`SCREEN_HEIGHT / 2);

    logic signed [`ACC_BITS-1:0] off_x;
    logic signed [`ACC_BITS-1:0] off_y;
    logic signed [`ACC_BITS-1:0] fov_x;
    logic signed [`ACC_BITS-1:0] fov_y;

    function automatic logic signed [`ACC_BITS-1:0] widen(input logic signed [`CAM_BITS-1:0] v);
        return {{(`ACC_BITS - `CAM_BITS){v[`CAM_BITS-1]}}, v};
    endfunction

    // Screen offsets centred on the middle pixel
    assign off_x = $signed({{(`ACC_BITS - `PIXEL_COORD_BITS){1'b0}}, pixel_x}) - HALF_W;
    assign off_y = $signed({{(`ACC_BITS - `PIXEL_COORD_BITS){1'b0}}, pixel_y}) - HALF_H;

    // Horizontal spread along the camera plane
    assign fov_x = (widen(cam_plane_x) * off_x) >>> `FRAC_BITS;
    assign fov_y = (widen(cam_plane_y) * off_x) >>> `FRAC_BITS;

    always_ff @(posedge clk) begin
        if (pixel_go) begin
            ray_pos_x <= widen(cam_x);
            ray_pos_y <= widen(cam_y);
            ray_pos_z <= widen(cam_z);
            ray_dir_x <= widen(cam_dir_x) + fov_x;
            ray_dir_y <= widen(cam_dir_y) + fov_y;
            // Vertical tilt from the line offset
            ray_dir_z <= widen(cam_dir_z) + (off_y <<< (`FRAC_BITS - 4));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ray_valid <= 1'b0;
        end else begin
            ray_valid <= pixel_go;
        end
    end

endmodule

//--- source/raycast_pkg.sv
// Voxel word type shared by the marcher, the shader and the top level

package raycast_pkg;

    // One 64-bit voxel word from the external memory
    // Raw view for the occupancy test, field view for shading
    typedef union packed {
        logic [63:0] raw;
        struct packed {
            logic [7:0] mat_props;
            logic [7:0] emissive;
            logic [7:0] alpha;
            logic [7:0] light;
            logic [7:0] red;
            logic [7:0] green;
            logic [7:0] blue;
            logic [3:0] mat_type;
            logic [3:0] unused;
        } fields;
    } voxel_word_t;

endpackage

//--- source/raycast_settings.svh
// Screen size, voxel grid and fixed-point widths
// Ray march step limit and hit threshold
`ifndef RAYCAST_SETTINGS_SVH
`define RAYCAST_SETTINGS_SVH

// Screen
`define SCREEN_WIDTH      16
`define SCREEN_HEIGHT     12
`define PIXEL_COORD_BITS  11

// Voxel grid, 64 per axis
`define VOXEL_COORD_BITS  6
`define VOXEL_ADDR_BITS   18

// Fixed-point camera and ray values
`define CAM_BITS          16
`define ACC_BITS          24
`define FRAC_BITS         8

// March limits
`define MAX_RAY_STEPS     40
`define ALPHA_HIT_MIN     10

`endif

//--- source/voxel_raycaster.sv
// Voxel ray-casting renderer, top level
// Chain of scanner, ray setup, marcher and shader
`timescale 1ns/100ps
`include "raycast_settings.svh"

module voxel_raycaster import raycast_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                start,
    input  logic signed [`CAM_BITS-1:0]         cam_x,
    input  logic signed [`CAM_BITS-1:0]         cam_y,
    input  logic signed [`CAM_BITS-1:0]         cam_z,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_x,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_y,
    input  logic signed [`CAM_BITS-1:0]         cam_dir_z,
    input  logic signed [`CAM_BITS-1:0]         cam_plane_x,
    input  logic signed [`CAM_BITS-1:0]         cam_plane_y,
    input  logic                                sel_active,
    input  logic        [`VOXEL_COORD_BITS-1:0] sel_voxel_x,
    input  logic        [`VOXEL_COORD_BITS-1:0] sel_voxel_y,
    input  logic        [`VOXEL_COORD_BITS-1:0] sel_voxel_z,
    output logic        [`VOXEL_ADDR_BITS-1:0]  voxel_addr,
    input  voxel_word_t                         voxel_data,
    output logic                                voxel_read_en,
    output logic        [31:0]                  pixel_word0,
    output logic        [31:0]                  pixel_word1,
    output logic        [31:0]                  pixel_addr,
    output logic                                pixel_write_en,
    output logic                                busy,
    output logic                                done
);

    // Scanner to ray setup
    logic                         pixel_go;
    logic [`PIXEL_COORD_BITS-1:0] pixel_x, pixel_y;

    // Ray setup to marcher
    logic                         ray_valid;
    logic signed [`ACC_BITS-1:0]  ray_pos_x, ray_pos_y, ray_pos_z;
    logic signed [`ACC_BITS-1:0]  ray_dir_x, ray_dir_y, ray_dir_z;

    // Marcher to shader
    logic                         march_done;
    logic                         hit;
    logic [`VOXEL_COORD_BITS-1:0] hit_x, hit_y, hit_z;
    voxel_word_t                  hit_word;
    logic [7:0]                   steps;

    pixel_scanner u_scanner (.*);
    ray_setup     u_setup   (.*);
    ray_marcher   u_marcher (.*);
    voxel_shader  u_shader  (.*);

endmodule

//--- source/voxel_shader.sv
// Hit and sky shading with selection highlight
// Packs the two 32-bit pixel words
`timescale 1ns/100ps
`include "raycast_settings.svh"

module voxel_shader import raycast_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         march_done,
    input  logic                         hit,
    input  logic [`VOXEL_COORD_BITS-1:0] hit_x,
    input  logic [`VOXEL_COORD_BITS-1:0] hit_y,
    input  logic [`VOXEL_COORD_BITS-1:0] hit_z,
    input  voxel_word_t                  hit_word,
    input  logic [7:0]                   steps,
    input  logic                         sel_active,
    input  logic [`VOXEL_COORD_BITS-1:0] sel_voxel_x,
    input  logic [`VOXEL_COORD_BITS-1:0] sel_voxel_y,
    input  logic [`VOXEL_COORD_BITS-1:0] sel_voxel_z,
    output logic [31:0]                  pixel_word0,
    output logic [31:0]                  pixel_word1,
    output logic                         pixel_write_en
);

    // Dark blue background
    localparam logic [31:0] SKY_WORD0 = {8'd0, 8'd0, 8'd255, 8'd0};
    localparam logic [31:0] SKY_WORD1 = {8'd30, 8'd30, 8'd60, 8'hFF};

    logic [7:0] lit_r, lit_g, lit_b;
    logic [7:0] base_r, base_g, base_b;
    logic [7:0] glow_r, glow_g, glow_b;
    logic [7:0] out_r, out_g, out_b;
    logic [7:0] reflection, refraction, emission, material_id;
    logic       selected;

    function automatic logic [7:0] sat_add(input logic [7:0] a, input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hFF : sum[7:0];
    endfunction

    function automatic logic [7:0] light_scale(input logic [7:0] c, input logic [7:0] l);
        logic [15:0] prod;
        prod = {8'd0, c} * {8'd0, l};
        return prod[15:8];
    endfunction

    // ----------------------------------------
    // Colour path
    // ----------------------------------------
    assign lit_r = light_scale(hit_word.fields.red, hit_word.fields.light);
    assign lit_g = light_scale(hit_word.fields.green, hit_word.fields.light);
    assign lit_b = light_scale(hit_word.fields.blue, hit_word.fields.light);

    // Unlit voxels fall back to their raw colour
    always_comb begin
        if (lit_r == 8'd0 && lit_g == 8'd0 && lit_b == 8'd0) begin
            base_r = hit_word.fields.red;
            base_g = hit_word.fields.green;
            base_b = hit_word.fields.blue;
        end else begin
            base_r = lit_r;
            base_g = lit_g;
            base_b = lit_b;
        end
    end

    assign glow_r = sat_add(base_r, hit_word.fields.emissive);
    assign glow_g = sat_add(base_g, hit_word.fields.emissive);
    assign glow_b = sat_add(base_b, hit_word.fields.emissive);

    assign selected = sel_active && hit_x == sel_voxel_x && hit_y == sel_voxel_y &&
                      hit_z == sel_voxel_z;

    // Purple tint on the selected voxel
    assign out_r = selected ? sat_add(glow_r, 8'd96) : glow_r;
    assign out_g = selected ? sat_add(glow_g, 8'd16) : glow_g;
    assign out_b = selected ? sat_add(glow_b, 8'd96) : glow_b;

    // ----------------------------------------
    // Material fields
    // ----------------------------------------
    assign material_id = {hit_word.fields.mat_type, 4'h0};
    assign emission    = (hit_word.fields.mat_type == 4'd1) ? hit_word.fields.emissive : 8'd0;

    always_comb begin
        case (hit_word.fields.mat_type)
            4'd3:    reflection = 8'd255;
            4'd5:    reflection = 8'd200;
            default: reflection = {hit_word.fields.mat_props[7:5], 5'd0};
        endcase
        case (hit_word.fields.mat_type)
            4'd5:    refraction = 8'd128;
            4'd2:    refraction = 8'd85;
            default: refraction = 8'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (march_done) begin
            if (hit) begin
                pixel_word0 <= {reflection, refraction, steps, emission};
                pixel_word1 <= {out_r, out_g, out_b, material_id};
            end else begin
                pixel_word0 <= SKY_WORD0;
                pixel_word1 <= SKY_WORD1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_write_en <= 1'b0;
        end else begin
            pixel_write_en <= march_done;
        end
    end

endmodule

//--- tb.f
+incdir+source
+incdir+tests
source/raycast_pkg.sv
source/pixel_scanner.sv
source/ray_setup.sv
source/ray_marcher.sv
source/voxel_shader.sv
source/voxel_raycaster.sv
tests/raycaster_tb.sv

//--- tests/raycaster_model.svh
// Reference model of the renderer for the testbench
// Random voxel memory, ray march of one pixel and its shading

// ----------------------------------------
// Model state
// ----------------------------------------
voxel_word_t                  mem_table [256];
int                           cam_v [8];
logic                         sel_on;
logic [`VOXEL_COORD_BITS-1:0] sel_v [3];
logic [`VOXEL_ADDR_BITS-1:0]  exp_addr [`MAX_RAY_STEPS];
int                           exp_fetches;
logic                         exp_hit;
voxel_word_t                  exp_voxel;
logic [`VOXEL_COORD_BITS-1:0] exp_hx, exp_hy, exp_hz;
logic [31:0]                  exp_word0, exp_word1;

// Table index folded from every address bit
function automatic logic [7:0] fold_index(input logic [`VOXEL_ADDR_BITS-1:0] a);
    return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]};
endfunction

function automatic int clamp_byte(input int v);
    return (v > 255) ? 255 : v;
endfunction

task automatic fill_memory();
    logic [31:0] ctl;
    voxel_word_t w;
    for (int i = 0; i < 256; i++) begin
        w.raw = {$random(seed), $random(seed)};
        ctl = $random(seed);
        // Every material type shows up across the table
        w.fields.mat_type = 4'(i % 6);
        if (ctl[2:0] == 3'd0)
            w.fields.light = 8'd0;
        if (ctl[5:3] == 3'd0)
            w.fields.emissive = 8'(200 + ctl[8:6] * 7);
        // Faint voxels that rays pass through
        if (ctl[10:9] == 2'd0)
            w.fields.alpha = 8'(ctl[15:12] % 11);
        if (ctl[31:16] % 3 == 0)
            w.raw = '0;
        mem_table[i] = w;
    end
endtask

// ----------------------------------------
// One pixel, march then shade
// ----------------------------------------
task automatic model_pixel(input int pix);
    int pos [3];
    int dir [3];
    int off_x, off_y, r, g, b, refl, refr;
    logic [`VOXEL_ADDR_BITS-1:0] a;
    voxel_word_t w;
    off_x = pix % `SCREEN_WIDTH - `SCREEN_WIDTH / 2;
    off_y = pix / `SCREEN_WIDTH - `SCREEN_HEIGHT / 2;
    for (int k = 0; k < 3; k++)
        pos[k] = cam_v[k];
    dir[0] = cam_v[3] + ((cam_v[6] * off_x) >>> `FRAC_BITS);
    dir[1] = cam_v[4] + ((cam_v[7] * off_x) >>> `FRAC_BITS);
    dir[2] = cam_v[5] + off_y * (1 << (`FRAC_BITS - 4));
    exp_hit = 1'b0;
    exp_fetches = 0;
    while (!exp_hit && exp_fetches < `MAX_RAY_STEPS) begin
        // Voxel under the current position, wrapped to the grid
        a = {pos[0][`FRAC_BITS +: `VOXEL_COORD_BITS], pos[1][`FRAC_BITS +: `VOXEL_COORD_BITS],
             pos[2][`FRAC_BITS +: `VOXEL_COORD_BITS]};
        exp_addr[exp_fetches] = a;
        exp_fetches++;
        w = mem_table[fold_index(a)];
        if (w.raw != 64'd0 && w.fields.alpha > `ALPHA_HIT_MIN) begin
            exp_hit = 1'b1;
            exp_voxel = w;
            {exp_hx, exp_hy, exp_hz} = a;
        end
        for (int k = 0; k < 3; k++)
            pos[k] += dir[k];
    end
    if (!exp_hit) begin
        exp_word0 = {8'd0, 8'd0, 8'd255, 8'd0};
        exp_word1 = {8'd30, 8'd30, 8'd60, 8'hFF};
    end else begin
        r = (int'(exp_voxel.fields.red) * int'(exp_voxel.fields.light)) >> 8;
        g = (int'(exp_voxel.fields.green) * int'(exp_voxel.fields.light)) >> 8;
        b = (int'(exp_voxel.fields.blue) * int'(exp_voxel.fields.light)) >> 8;
        if (r == 0 && g == 0 && b == 0) begin
            r = exp_voxel.fields.red;
            g = exp_voxel.fields.green;
            b = exp_voxel.fields.blue;
        end
        r = clamp_byte(r + exp_voxel.fields.emissive);
        g = clamp_byte(g + exp_voxel.fields.emissive);
        b = clamp_byte(b + exp_voxel.fields.emissive);
        if (sel_on && {exp_hx, exp_hy, exp_hz} == {sel_v[0], sel_v[1], sel_v[2]}) begin
            r = clamp_byte(r + 96);
            g = clamp_byte(g + 16);
            b = clamp_byte(b + 96);
        end
        case (exp_voxel.fields.mat_type)
            4'd3:    refl = 255;
            4'd5:    refl = 200;
            default: refl = exp_voxel.fields.mat_props & 8'hE0;
        endcase
        case (exp_voxel.fields.mat_type)
            4'd5:    refr = 128;
            4'd2:    refr = 85;
            default: refr = 0;
        endcase
        exp_word0 = {8'(refl), 8'(refr), 8'(exp_fetches),
                     (exp_voxel.fields.mat_type == 4'd1) ? exp_voxel.fields.emissive : 8'd0};
        exp_word1 = {8'(r), 8'(g), 8'(b), exp_voxel.fields.mat_type, 4'h0};
    end
endtask

//--- tests/raycaster_tb.sv
// Testbench for the voxel ray-casting renderer
// Random voxel memory and cameras, each pixel checked against the model
`timescale 1ns/100ps
`include "raycast_settings.svh"

module raycaster_tb import raycast_pkg::*; ();

    localparam int PIXELS        = `SCREEN_WIDTH * `SCREEN_HEIGHT;
    localparam int FRAME_TIMEOUT = 40000;
    localparam int RANDOM_FRAMES = 5;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic signed [`CAM_BITS-1:0]         cam_x, cam_y, cam_z;
    logic signed [`CAM_BITS-1:0]         cam_dir_x, cam_dir_y, cam_dir_z;
    logic signed [`CAM_BITS-1:0]         cam_plane_x, cam_plane_y;
    logic                                sel_active;
    logic        [`VOXEL_COORD_BITS-1:0] sel_voxel_x, sel_voxel_y, sel_voxel_z;
    logic        [`VOXEL_ADDR_BITS-1:0]  voxel_addr;
    voxel_word_t                         voxel_data;
    logic                                voxel_read_en;
    logic        [31:0]                  pixel_word0, pixel_word1, pixel_addr;
    logic                                pixel_write_en;
    logic                                busy;
    logic                                done;
    integer                              seed;

    // Hit voxel and view kept for the selection frame
    logic                                have_sel;
    logic        [`VOXEL_COORD_BITS-1:0] keep_sel [3];
    int                                  keep_cam [8];

    `include "raycaster_model.svh"

    voxel_raycaster dut0 (.*);

    // Voxel memory answers within the fetch cycle
    assign voxel_data = voxel_read_en ? mem_table[fold_index(voxel_addr)] : '0;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [`VOXEL_ADDR_BITS-1:0] got,
                              input logic [`VOXEL_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_voxel(input string name, input voxel_word_t got,
                               input voxel_word_t exp);
        if (got.raw !== exp.raw) begin
            $display("[ERROR] %s got %h expected %h", name, got.raw, exp.raw);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic pick_camera();
        for (int k = 0; k < 3; k++) begin
            cam_v[k]     = $random(seed) & 32'h3FFF;
            cam_v[k + 3] = $random(seed) % 33;
        end
        cam_v[6] = $random(seed) % 65;
        cam_v[7] = $random(seed) % 65;
    endtask

    task automatic apply_camera();
        cam_x       <= cam_v[0][`CAM_BITS-1:0];
        cam_y       <= cam_v[1][`CAM_BITS-1:0];
        cam_z       <= cam_v[2][`CAM_BITS-1:0];
        cam_dir_x   <= cam_v[3][`CAM_BITS-1:0];
        cam_dir_y   <= cam_v[4][`CAM_BITS-1:0];
        cam_dir_z   <= cam_v[5][`CAM_BITS-1:0];
        cam_plane_x <= cam_v[6][`CAM_BITS-1:0];
        cam_plane_y <= cam_v[7][`CAM_BITS-1:0];
        sel_active  <= sel_on;
        sel_voxel_x <= sel_v[0];
        sel_voxel_y <= sel_v[1];
        sel_voxel_z <= sel_v[2];
    endtask

    task automatic run_frame(input int frame);
        int   cycles;
        int   pix;
        int   reads;
        int   hits;
        logic finished;
        cycles = 0;
        pix = 0;
        reads = 0;
        hits = 0;
        finished = 1'b0;
        model_pixel(0);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!finished) begin
            @(negedge clk);
            check_flag("busy", busy, !done);
            if (voxel_read_en) begin
                if (reads >= exp_fetches) begin
                    $display("Pixel %0d read more voxels than its march allows", pix);
                    stop_run();
                end
                check_addr("voxel_addr", voxel_addr, exp_addr[reads]);
                reads++;
            end
            if (dut0.march_done) begin
                check_flag("hit", dut0.hit, exp_hit);
                if (exp_hit)
                    check_voxel("hit_word", dut0.hit_word, exp_voxel);
            end
            if (pixel_write_en) begin
                if (pix >= PIXELS) begin
                    $display("Frame %0d wrote more pixels than the screen holds", frame);
                    stop_run();
                end
                check_word("voxel reads", reads, exp_fetches);
                check_word("pixel_addr", pixel_addr, pix);
                check_word("pixel_word0", pixel_word0, exp_word0);
                check_word("pixel_word1", pixel_word1, exp_word1);
                if (exp_hit) begin
                    hits++;
                    have_sel = 1'b1;
                    keep_sel[0] = exp_hx;
                    keep_sel[1] = exp_hy;
                    keep_sel[2] = exp_hz;
                    keep_cam = cam_v;
                end
                pix++;
                reads = 0;
                if (pix < PIXELS)
                    model_pixel(pix);
            end
            finished = done;
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                $display("Timeout waiting for done in frame %0d", frame);
                stop_run();
            end
            @(posedge clk);
            // A start in mid frame must not restart the scan
            start <= (cycles == 50);
        end
        check_word("pixel count", pix, PIXELS);
        $display("Frame %0d rendered, %0d of %0d pixels hit a voxel", frame, hits, PIXELS);
        repeat (4) begin
            @(negedge clk);
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_flag("pixel_write_en", pixel_write_en, 1'b0);
        end
    endtask

    initial begin
        seed = 23964;
        have_sel = 1'b0;
        sel_on = 1'b0;
        foreach (sel_v[k])
            sel_v[k] = '0;
        fill_memory();
        pick_camera();
        rst_n <= 1'b0;
        start <= 1'b0;
        apply_camera();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int f = 0; f < RANDOM_FRAMES; f++) begin
            pick_camera();
            @(posedge clk);
            apply_camera();
            run_frame(f);
        end
        if (!have_sel) begin
            $display("No frame hit a voxel, so none can be selected");
            stop_run();
        end
        // Same view again with one hit voxel selected
        cam_v = keep_cam;
        sel_on = 1'b1;
        sel_v = keep_sel;
        @(posedge clk);
        apply_camera();
        run_frame(RANDOM_FRAMES);
        $display("PASS: all tests");
        $finish;
    end

endmodule
